//--- src/sd_pkg.sv
package sd_pkg;

  // card clock timing, in system clocks per half period
  localparam logic [7:0] slow_half_period = 8'd125;
  localparam logic [7:0] fast_half_period = 8'd2;

  // waits, counted in card clocks
  localparam logic [15:0] powerup_sclk = 16'd80;
  localparam logic [7:0] resp_timeout = 8'd100;
  localparam logic [15:0] token_timeout = 16'd8000;
  localparam logic [3:0] max_retries = 4'd10;

  localparam int frame_bits = 48;
  localparam int resp_max_bits = 40;
  localparam int block_bytes = 512;

  typedef logic [5:0] cmd_index_t;
  typedef logic [31:0] cmd_arg_t;
  typedef logic [resp_max_bits-1:0] resp_t;
  typedef logic [7:0] r1_t;
  typedef logic [7:0] byte_t;

  // msb goes out first
  typedef struct packed {
    logic [1:0] start;
    cmd_index_t index;
    cmd_arg_t arg;
    logic [6:0] crc;
    logic stop;
  } sd_frame_t;

  // number of response bits, R3 shares the R7 length
  typedef enum logic [5:0] {
    r1_len = 6'd8,
    r7_len = 6'd40
  } resp_len_t;

  typedef enum logic [2:0] {
    rx_idle,
    rx_wait,
    rx_resp,
    rx_hunt,
    rx_data
  } rx_state_t;

  typedef enum logic [2:0] {
    sq_power,
    sq_send,
    sq_tx,
    sq_rx,
    sq_done,
    sq_error
  } seq_state_t;

  typedef enum logic [2:0] {
    step_cmd0,
    step_cmd8,
    step_cmd58a,
    step_cmd55,
    step_acmd41,
    step_cmd58b,
    step_cmd16,
    step_cmd17
  } seq_step_t;

  localparam cmd_index_t cmd0 = 6'd0;
  localparam cmd_index_t cmd8 = 6'd8;
  localparam cmd_index_t cmd16 = 6'd16;
  localparam cmd_index_t cmd17 = 6'd17;
  localparam cmd_index_t cmd55 = 6'd55;
  localparam cmd_index_t acmd41 = 6'd41;
  localparam cmd_index_t cmd58 = 6'd58;

  localparam r1_t r1_idle = 8'h01;
  localparam r1_t r1_ready = 8'h00;
  localparam r1_t r1_illegal = 8'h05;
  localparam byte_t data_token = 8'hFE;
  localparam cmd_arg_t cmd8_arg = 32'h0000_01AA;

  // crc7 over start bits, index and argument
  // generator x^7 + x^3 + 1, msb first
  function automatic logic [6:0] crc7(input logic [39:0] data);
    logic [6:0] crc;
    logic fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = data[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) begin
        crc = crc ^ 7'h09;
      end
    end
    return crc;
  endfunction

endpackage

//--- src/sd_if.sv
// command request from sequencer to transmitter
interface sd_cmd_if import sd_pkg::*; ();
  logic cmd_start;
  cmd_index_t cmd_index;
  cmd_arg_t cmd_arg;
  logic cmd_done;

  modport seq (
    output cmd_start, cmd_index, cmd_arg,
    input cmd_done
  );

  modport tx (
    input cmd_start, cmd_index, cmd_arg,
    output cmd_done
  );
endinterface

// response capture between sequencer and receiver
interface sd_resp_if import sd_pkg::*; ();
  logic resp_arm;
  resp_len_t resp_len;
  logic want_block;
  logic resp_done;
  resp_t resp_data;
  // qualified by resp_done
  logic resp_timeout;

  modport seq (
    output resp_arm, resp_len, want_block,
    input resp_done, resp_data, resp_timeout
  );

  modport rx (
    input resp_arm, resp_len, want_block,
    output resp_done, resp_data, resp_timeout
  );
endinterface

//--- src/sd_clk_gen.sv
module sd_clk_gen import sd_pkg::*; #(
  parameter logic [7:0] slow_div = slow_half_period,
  parameter logic [7:0] fast_div = fast_half_period
) (
  input logic clk,
  input logic arst_n,
  input logic sclk_en,
  input logic fast_sel,
  output logic sd_cclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  logic [7:0] cnt;
  logic [7:0] half_q;
  logic [7:0] half_sel;
  logic wrap;

  assign half_sel = fast_sel ? fast_div : slow_div;
  assign wrap = sclk_en && (cnt == half_q - 8'd1);

  // strobes mark the system clock edge on which sd_cclk toggles
  assign sclk_rise = wrap && !sd_cclk;
  assign sclk_fall = wrap && sd_cclk;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      half_q <= slow_div;
      sd_cclk <= 1'b0;
    end else if (!sclk_en) begin
      // parked low
      cnt <= '0;
      half_q <= half_sel;
      sd_cclk <= 1'b0;
    end else if (wrap) begin
      cnt <= '0;
      // rate change only at a half period boundary
      half_q <= half_sel;
      sd_cclk <= !sd_cclk;
    end else begin
      cnt <= cnt + 8'd1;
    end
  end

  // every card clock rise was announced by a rise strobe
  a_rise_strobed: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(sd_cclk) |-> $past(sclk_rise));

endmodule

//--- src/sd_cmd_tx.sv
module sd_cmd_tx import sd_pkg::*; (
  input logic clk,
  input logic arst_n,
  input logic sclk_fall,
  sd_cmd_if.tx cmd,
  output logic sd_cmd
);

  sd_frame_t frame_d;
  logic [frame_bits-1:0] shift_q;
  logic [5:0] bit_cnt;
  logic busy;
  logic last_fall;

  // frame assembly, crc over the first 40 bits
  always_comb begin
    frame_d.start = 2'b01;
    frame_d.index = cmd.cmd_index;
    frame_d.arg = cmd.cmd_arg;
    frame_d.crc = crc7({2'b01, cmd.cmd_index, cmd.cmd_arg});
    frame_d.stop = 1'b1;
  end

  // falling strobe after bit 47 closes the frame
  assign last_fall = busy && sclk_fall && (bit_cnt == 6'(frame_bits));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      bit_cnt <= '0;
      sd_cmd <= 1'b1;
      cmd.cmd_done <= 1'b0;
    end else begin
      cmd.cmd_done <= last_fall;
      if (cmd.cmd_start) begin
        busy <= 1'b1;
        bit_cnt <= '0;
      end else if (last_fall) begin
        busy <= 1'b0;
        // line back to idle high
        sd_cmd <= 1'b1;
      end else if (busy && sclk_fall) begin
        sd_cmd <= shift_q[frame_bits-1];
        bit_cnt <= bit_cnt + 6'd1;
      end
    end
  end

  // frame payload shifter
  always_ff @(posedge clk) begin
    if (cmd.cmd_start) begin
      shift_q <= frame_d;
    end else if (busy && sclk_fall) begin
      shift_q <= {shift_q[frame_bits-2:0], 1'b1};
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    cmd.cmd_start |-> !busy);

endmodule

//--- src/sd_resp_rx.sv
module sd_resp_rx import sd_pkg::*; (
  input logic clk,
  input logic arst_n,
  input logic sclk_rise,
  input logic sd_data0,
  sd_resp_if.rx resp,
  output byte_t blk_byte,
  output logic blk_valid
);

  rx_state_t state;
  resp_len_t len_q;
  logic want_blk_q;
  logic [15:0] wait_cnt;
  logic [5:0] bit_cnt;
  logic [2:0] bit_idx;
  logic [9:0] byte_cnt;
  byte_t byte_sr;
  byte_t byte_full;

  // byte completed by the bit on the line now
  assign byte_full = {byte_sr[6:0], sd_data0};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= rx_idle;
      len_q <= r1_len;
      want_blk_q <= 1'b0;
      wait_cnt <= '0;
      bit_cnt <= '0;
      bit_idx <= '0;
      byte_cnt <= '0;
      blk_valid <= 1'b0;
      resp.resp_done <= 1'b0;
      resp.resp_timeout <= 1'b0;
    end else begin
      blk_valid <= 1'b0;
      resp.resp_done <= 1'b0;
      case (state)
        rx_idle: begin
          if (resp.resp_arm) begin
            len_q <= resp.resp_len;
            want_blk_q <= resp.want_block;
            wait_cnt <= '0;
            state <= rx_wait;
          end
        end
        rx_wait: begin
          // first 0 is the start of R1
          if (sclk_rise) begin
            if (!sd_data0) begin
              bit_cnt <= 6'd1;
              state <= rx_resp;
            end else if (wait_cnt == 16'(resp_timeout) - 16'd1) begin
              resp.resp_done <= 1'b1;
              resp.resp_timeout <= 1'b1;
              state <= rx_idle;
            end else begin
              wait_cnt <= wait_cnt + 16'd1;
            end
          end
        end
        rx_resp: begin
          if (sclk_rise) begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == len_q - 6'd1) begin
              if (want_blk_q) begin
                wait_cnt <= '0;
                bit_idx <= '0;
                state <= rx_hunt;
              end else begin
                resp.resp_done <= 1'b1;
                resp.resp_timeout <= 1'b0;
                state <= rx_idle;
              end
            end
          end
        end
        rx_hunt: begin
          // token search on byte boundaries after the response
          if (sclk_rise) begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7 && byte_full == data_token) begin
              byte_cnt <= '0;
              state <= rx_data;
            end else if (wait_cnt == token_timeout - 16'd1) begin
              resp.resp_done <= 1'b1;
              resp.resp_timeout <= 1'b1;
              state <= rx_idle;
            end else begin
              wait_cnt <= wait_cnt + 16'd1;
            end
          end
        end
        rx_data: begin
          // 512 data bytes then 2 crc bytes, crc dropped
          if (sclk_rise) begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              byte_cnt <= byte_cnt + 10'd1;
              if (byte_cnt < 10'(block_bytes)) begin
                blk_valid <= 1'b1;
              end
              if (byte_cnt == 10'(block_bytes + 1)) begin
                resp.resp_done <= 1'b1;
                resp.resp_timeout <= 1'b0;
                state <= rx_idle;
              end
            end
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // response bits and block data
  always_ff @(posedge clk) begin
    if (state == rx_idle && resp.resp_arm) begin
      // zero data on a timeout
      resp.resp_data <= '0;
    end else if (state == rx_resp && sclk_rise) begin
      resp.resp_data[resp_max_bits-1-int'(bit_cnt)] <= sd_data0;
    end
    if (sclk_rise) begin
      byte_sr <= byte_full;
    end
    if (state == rx_data && sclk_rise && bit_idx == 3'd7) begin
      blk_byte <= byte_full;
    end
  end

  // single cycle pulse, block phase still open for the crc bytes
  a_blk_in_data: assert property (@(posedge clk) disable iff (!arst_n)
    blk_valid |=> !blk_valid && state == rx_data);

endmodule

//--- src/sd_init_seq.sv
module sd_init_seq import sd_pkg::*; #(
  parameter logic [15:0] powerup_sclk_cycles = powerup_sclk
) (
  input logic clk,
  input logic arst_n,
  input logic sclk_rise,
  sd_cmd_if.seq cmd,
  sd_resp_if.seq resp,
  output logic sd_cs,
  output logic sclk_en,
  output logic fast_sel,
  output logic init_done,
  output logic init_error,
  output logic card_hc
);

  seq_state_t state;
  seq_step_t step;
  logic [15:0] pu_cnt;
  logic [3:0] cmd0_tries;
  logic [3:0] acmd_tries;
  r1_t r1;
  logic cmd8_ok;

  assign r1 = resp.resp_data[39:32];
  // illegal command means a v1 card, else echo must match
  assign cmd8_ok = (r1 == r1_illegal) ||
                   (r1 == r1_idle && resp.resp_data[15:8] == 8'h01 &&
                    resp.resp_data[7:0] == cmd8_arg[7:0]);

  // command table per step
  always_comb begin
    cmd.cmd_index = cmd0;
    cmd.cmd_arg = '0;
    resp.resp_len = r1_len;
    resp.want_block = 1'b0;
    case (step)
      step_cmd0: cmd.cmd_index = cmd0;
      step_cmd8: begin
        cmd.cmd_index = cmd8;
        cmd.cmd_arg = cmd8_arg;
        resp.resp_len = r7_len;
      end
      step_cmd58a, step_cmd58b: begin
        cmd.cmd_index = cmd58;
        resp.resp_len = r7_len;
      end
      step_cmd55: cmd.cmd_index = cmd55;
      step_acmd41: begin
        cmd.cmd_index = acmd41;
        // hcs set
        cmd.cmd_arg = 32'h4000_0000;
      end
      step_cmd16: begin
        cmd.cmd_index = cmd16;
        cmd.cmd_arg = 32'(block_bytes);
      end
      step_cmd17: begin
        cmd.cmd_index = cmd17;
        resp.want_block = 1'b1;
      end
      default: cmd.cmd_index = cmd0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= sq_power;
      step <= step_cmd0;
      pu_cnt <= '0;
      cmd0_tries <= '0;
      acmd_tries <= '0;
      sd_cs <= 1'b1;
      sclk_en <= 1'b0;
      fast_sel <= 1'b0;
      init_done <= 1'b0;
      init_error <= 1'b0;
      card_hc <= 1'b0;
      cmd.cmd_start <= 1'b0;
      resp.resp_arm <= 1'b0;
    end else begin
      cmd.cmd_start <= 1'b0;
      // arm the receiver right after the frame ends
      resp.resp_arm <= (state == sq_tx) && cmd.cmd_done;
      case (state)
        sq_power: begin
          sclk_en <= 1'b1;
          if (sclk_rise) begin
            pu_cnt <= pu_cnt + 16'd1;
            if (pu_cnt == powerup_sclk_cycles - 16'd1) begin
              sd_cs <= 1'b0;
              state <= sq_send;
            end
          end
        end
        sq_send: begin
          cmd.cmd_start <= 1'b1;
          state <= sq_tx;
        end
        sq_tx: begin
          if (cmd.cmd_done) begin
            state <= sq_rx;
          end
        end
        sq_rx: begin
          if (resp.resp_done) begin
            state <= sq_send;
            if (step == step_cmd0) begin
              // timeouts on cmd0 count as retries
              if (!resp.resp_timeout && r1 == r1_idle) begin
                step <= step_cmd8;
              end else if (cmd0_tries == max_retries - 4'd1) begin
                state <= sq_error;
              end else begin
                cmd0_tries <= cmd0_tries + 4'd1;
              end
            end else if (resp.resp_timeout) begin
              state <= sq_error;
            end else begin
              case (step)
                step_cmd8: begin
                  if (cmd8_ok) begin
                    step <= step_cmd58a;
                  end else begin
                    state <= sq_error;
                  end
                end
                step_cmd58a: begin
                  // ccs bit of the ocr
                  card_hc <= resp.resp_data[30];
                  step <= step_cmd55;
                end
                step_cmd55: begin
                  if (r1 == r1_idle || r1 == r1_ready) begin
                    step <= step_acmd41;
                  end else begin
                    state <= sq_error;
                  end
                end
                step_acmd41: begin
                  if (r1 == r1_ready) begin
                    step <= step_cmd58b;
                  end else if (r1 != r1_idle || acmd_tries == max_retries - 4'd1) begin
                    state <= sq_error;
                  end else begin
                    acmd_tries <= acmd_tries + 4'd1;
                    step <= step_cmd55;
                  end
                end
                step_cmd58b: begin
                  fast_sel <= 1'b1;
                  step <= step_cmd16;
                end
                step_cmd16: begin
                  if (r1 == r1_ready) begin
                    step <= step_cmd17;
                  end else begin
                    state <= sq_error;
                  end
                end
                default: begin
                  // block read finished
                  state <= (r1 == r1_ready) ? sq_done : sq_error;
                end
              endcase
            end
          end
        end
        sq_done: begin
          init_done <= 1'b1;
          sd_cs <= 1'b1;
          sclk_en <= 1'b0;
        end
        default: begin
          init_error <= 1'b1;
          sd_cs <= 1'b1;
          sclk_en <= 1'b0;
        end
      endcase
    end
  end

  a_end_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(init_done && init_error));

  a_end_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    (init_done |=> init_done) and (init_error |=> init_error));

endmodule

//--- src/sd_spi_init.sv
module sd_spi_init import sd_pkg::*; #(
  parameter logic [15:0] powerup_sclk_cycles = powerup_sclk,
  parameter logic [7:0] slow_div = slow_half_period,
  parameter logic [7:0] fast_div = fast_half_period
) (
  input logic clk,
  input logic arst_n,
  input logic sd_data0,
  output logic sd_cclk,
  output logic sd_cmd,
  output logic sd_cs,
  output logic init_done,
  output logic init_error,
  output logic card_hc,
  output byte_t blk_byte,
  output logic blk_valid
);

  logic sclk_en;
  logic fast_sel;
  logic sclk_rise;
  logic sclk_fall;

  sd_cmd_if u_cmd_if ();
  sd_resp_if u_resp_if ();

  // card clock and edge strobes
  sd_clk_gen #(
    .slow_div(slow_div),
    .fast_div(fast_div)
  ) u_clk_gen (
    .clk(clk),
    .arst_n(arst_n),
    .sclk_en(sclk_en),
    .fast_sel(fast_sel),
    .sd_cclk(sd_cclk),
    .sclk_rise(sclk_rise),
    .sclk_fall(sclk_fall)
  );

  sd_init_seq #(
    .powerup_sclk_cycles(powerup_sclk_cycles)
  ) u_init_seq (
    .clk(clk),
    .arst_n(arst_n),
    .sclk_rise(sclk_rise),
    .cmd(u_cmd_if.seq),
    .resp(u_resp_if.seq),
    .sd_cs(sd_cs),
    .sclk_en(sclk_en),
    .fast_sel(fast_sel),
    .init_done(init_done),
    .init_error(init_error),
    .card_hc(card_hc)
  );

  // command line out
  sd_cmd_tx u_cmd_tx (
    .clk(clk),
    .arst_n(arst_n),
    .sclk_fall(sclk_fall),
    .cmd(u_cmd_if.tx),
    .sd_cmd(sd_cmd)
  );

  // data line in
  sd_resp_rx u_resp_rx (
    .clk(clk),
    .arst_n(arst_n),
    .sclk_rise(sclk_rise),
    .sd_data0(sd_data0),
    .resp(u_resp_if.rx),
    .blk_byte(blk_byte),
    .blk_valid(blk_valid)
  );

endmodule

//--- dv/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int half_period = 20,
  parameter int reset_cycles = 8
) (
  input logic rst_req,
  output logic clk,
  output logic arst_n
);

  int rst_cnt;

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    rst_cnt = reset_cycles;
  end

  always #(half_period) clk = ~clk;

  // request reloads the reset length
  always @(posedge clk) begin
    if (rst_req) begin
      rst_cnt <= reset_cycles;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  // reset edges land on the falling clock edge
  always @(negedge clk) begin
    arst_n <= (rst_cnt == 0);
  end

endmodule

//--- dv/sd_card_model.sv
module sd_card_model import sd_pkg::*; (
  input logic arst_n,
  input logic sd_cclk,
  input logic sd_cs,
  input logic sd_cmd,
  output logic sd_data0,
  // answer knobs
  input r1_t cmd0_r1,
  input byte_t cmd8_pattern,
  input logic ocr_hc,
  input logic [3:0] busy_polls,
  input logic mute,
  // observed traffic
  output r1_t crc_errs,
  output r1_t n_cmd0,
  output r1_t n_cmd8,
  output r1_t n_cmd55,
  output r1_t n_log
);

  cmd_index_t log_mem [0:31];
  logic [frame_bits-1:0] rx_sr;
  int rx_cnt;
  bit tx_q [$];
  logic [3:0] busy_left;
  logic idle_st;
  integer seed;

  task automatic clear_state();
    rx_cnt = 0;
    crc_errs = '0;
    n_cmd0 = '0;
    n_cmd8 = '0;
    n_cmd55 = '0;
    n_log = '0;
    tx_q.delete();
    sd_data0 = 1'b1;
    idle_st = 1'b1;
    busy_left = '0;
  endtask

  task automatic push_byte(input byte_t b);
    for (int i = 7; i >= 0; i--) begin
      tx_q.push_back(b[i]);
    end
  endtask

  task automatic decode_cmd();
    sd_frame_t f;
    byte_t rsp [$];
    integer rnd;
    logic [31:0] ocr;
    f = rx_sr;
    // crc7 recomputed over start bits, index, argument
    if (f.crc != crc7({f.start, f.index, f.arg}) || f.stop != 1'b1) begin
      crc_errs = crc_errs + 8'd1;
    end
    if (n_log < 8'd32) begin
      log_mem[n_log] = f.index;
    end
    n_log = n_log + 8'd1;
    ocr = {1'b1, ocr_hc, 6'b0, 24'hFF8000};
    case (f.index)
      cmd0: begin
        n_cmd0 = n_cmd0 + 8'd1;
        idle_st = 1'b1;
        busy_left = busy_polls;
        rsp.push_back(cmd0_r1);
      end
      cmd8: begin
        n_cmd8 = n_cmd8 + 8'd1;
        // R7 with 2.7-3.6 V accepted and the echo byte
        rsp.push_back(r1_idle);
        rsp.push_back(8'h00);
        rsp.push_back(8'h00);
        rsp.push_back(8'h01);
        rsp.push_back(cmd8_pattern);
      end
      cmd58: begin
        rsp.push_back(idle_st ? r1_idle : r1_ready);
        for (int i = 3; i >= 0; i--) begin
          rsp.push_back(ocr[8*i +: 8]);
        end
      end
      cmd55: begin
        n_cmd55 = n_cmd55 + 8'd1;
        rsp.push_back(idle_st ? r1_idle : r1_ready);
      end
      acmd41: begin
        if (busy_left != 0) begin
          busy_left = busy_left - 4'd1;
          rsp.push_back(r1_idle);
        end else begin
          idle_st = 1'b0;
          rsp.push_back(r1_ready);
        end
      end
      cmd16: rsp.push_back(r1_ready);
      cmd17: begin
        rsp.push_back(r1_ready);
        // two fill bytes, then token and block
        rsp.push_back(8'hFF);
        rsp.push_back(8'hFF);
        rsp.push_back(data_token);
        seed = 32'h7cc;
        for (int i = 0; i < block_bytes; i++) begin
          rnd = $random(seed);
          rsp.push_back(rnd[7:0]);
        end
        // crc16 bytes, never checked by the host
        rsp.push_back(8'h5A);
        rsp.push_back(8'hC3);
      end
      default: rsp.push_back(r1_illegal);
    endcase
    if (!mute) begin
      // two idle clocks before the response
      tx_q.push_back(1'b1);
      tx_q.push_back(1'b1);
      for (int k = 0; k < rsp.size(); k++) begin
        push_byte(rsp[k]);
      end
    end
  endtask

  initial clear_state();

  always @(negedge arst_n) begin
    clear_state();
  end

  // command framing, start bit is the first 0 with cs low
  always @(posedge sd_cclk) begin
    if (arst_n && !sd_cs && (rx_cnt > 0 || !sd_cmd)) begin
      rx_sr = {rx_sr[frame_bits-2:0], sd_cmd};
      rx_cnt = rx_cnt + 1;
      if (rx_cnt == frame_bits) begin
        rx_cnt = 0;
        decode_cmd();
      end
    end
  end

  // data out changes on the falling card clock
  always @(negedge sd_cclk) begin
    if (arst_n && tx_q.size() > 0) begin
      sd_data0 <= tx_q.pop_front();
    end else begin
      sd_data0 <= 1'b1;
    end
  end

endmodule

//--- dv/tb_sd_spi_init.sv
module tb_sd_spi_init import sd_pkg::*; ();

  localparam int n_tests = 5;
  localparam int cycles_per_test = 60000;
  localparam int cycle_limit = n_tests * cycles_per_test;

  logic clk;
  logic arst_n;
  logic rst_req;
  logic sd_cclk;
  logic sd_cmd;
  logic sd_cs;
  logic sd_data0;
  logic init_done;
  logic init_error;
  logic card_hc;
  logic blk_valid;
  byte_t blk_byte;

  // card knobs
  r1_t cmd0_r1;
  byte_t cmd8_pattern;
  logic ocr_hc;
  logic [3:0] busy_polls;
  logic mute;
  r1_t crc_errs;
  r1_t n_cmd0;
  r1_t n_cmd8;
  r1_t n_cmd55;
  r1_t n_log;

  byte_t blk_q [$];
  int errors = 0;
  int failed = 0;
  int cycles = 0;

  tb_clk_gen u_tb_clk_gen (
    .rst_req(rst_req),
    .clk(clk),
    .arst_n(arst_n)
  );

  sd_spi_init #(
    .slow_div(8'd4),
    .fast_div(8'd1)
  ) u_sd_spi_init (
    .clk(clk),
    .arst_n(arst_n),
    .sd_data0(sd_data0),
    .sd_cclk(sd_cclk),
    .sd_cmd(sd_cmd),
    .sd_cs(sd_cs),
    .init_done(init_done),
    .init_error(init_error),
    .card_hc(card_hc),
    .blk_byte(blk_byte),
    .blk_valid(blk_valid)
  );

  sd_card_model u_card (
    .arst_n(arst_n),
    .sd_cclk(sd_cclk),
    .sd_cs(sd_cs),
    .sd_cmd(sd_cmd),
    .sd_data0(sd_data0),
    .cmd0_r1(cmd0_r1),
    .cmd8_pattern(cmd8_pattern),
    .ocr_hc(ocr_hc),
    .busy_polls(busy_polls),
    .mute(mute),
    .crc_errs(crc_errs),
    .n_cmd0(n_cmd0),
    .n_cmd8(n_cmd8),
    .n_cmd55(n_cmd55),
    .n_log(n_log)
  );

  // block bytes, sampled mid cycle
  always @(negedge clk) begin
    if (blk_valid === 1'b1) begin
      blk_q.push_back(blk_byte);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit) begin
      $display("Timeout: no end of run within %0d clock cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic cmp_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_r1(input string what, input r1_t got, input r1_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_index(input string what, input cmd_index_t got, input cmd_index_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got CMD%0d expected CMD%0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // init order: 0, 8, 58, (55, 41) per poll, 58, 16, 17
  function automatic cmd_index_t expected_cmd(input int busy, input int pos);
    int loop_end;
    loop_end = 3 + 2 * (busy + 1);
    if (pos == 0) return cmd0;
    if (pos == 1) return cmd8;
    if (pos == 2) return cmd58;
    if (pos < loop_end) return (pos % 2 == 1) ? cmd55 : acmd41;
    if (pos == loop_end) return cmd58;
    if (pos == loop_end + 1) return cmd16;
    return cmd17;
  endfunction

  task automatic set_card(input r1_t r0, input byte_t pat, input logic hc,
                          input logic [3:0] busy, input logic quiet);
    @(negedge clk);
    cmd0_r1 = r0;
    cmd8_pattern = pat;
    ocr_hc = hc;
    busy_polls = busy;
    mute = quiet;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_req = 1'b1;
    @(negedge clk);
    rst_req = 1'b0;
    @(posedge arst_n);
    blk_q.delete();
  endtask

  task automatic wait_end();
    wait (init_done === 1'b1 || init_error === 1'b1);
    @(negedge clk);
  endtask

  task automatic check_order(input int busy);
    int len;
    len = 6 + 2 * (busy + 1);
    cmp_r1("command count", n_log, r1_t'(len));
    for (int i = 0; i < len && i < int'(n_log); i++) begin
      cmp_index($sformatf("command %0d", i), u_card.log_mem[i], expected_cmd(busy, i));
    end
  endtask

  task automatic check_block();
    integer exp_seed;
    integer rnd;
    exp_seed = 32'h7cc;
    if (blk_q.size() != block_bytes) begin
      $display("[ERROR] %0t: block length got %0d bytes expected %0d",
               $time, blk_q.size(), block_bytes);
      errors++;
    end
    for (int i = 0; i < blk_q.size() && i < block_bytes; i++) begin
      rnd = $random(exp_seed);
      cmp_byte($sformatf("block byte %0d", i), blk_q[i], rnd[7:0]);
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    if (errors == err0) begin
      $display("test %s: PASS", name);
    end else begin
      failed++;
      $display("test %s: FAIL with %0d errors", name, errors - err0);
    end
  endtask

  task automatic normal_hc_card();
    int err0;
    err0 = errors;
    set_card(r1_idle, 8'hAA, 1'b1, 4'd1, 1'b0);
    apply_reset();
    // idle levels straight out of reset
    cmp_bit("sd_cs after reset", sd_cs, 1'b1);
    cmp_bit("sd_cmd after reset", sd_cmd, 1'b1);
    cmp_bit("sd_cclk after reset", sd_cclk, 1'b0);
    cmp_bit("blk_valid after reset", blk_valid, 1'b0);
    cmp_bit("init_done after reset", init_done, 1'b0);
    cmp_bit("init_error after reset", init_error, 1'b0);
    wait_end();
    cmp_bit("init_done", init_done, 1'b1);
    cmp_bit("init_error", init_error, 1'b0);
    cmp_bit("card_hc", card_hc, 1'b1);
    cmp_r1("crc7 mismatches", crc_errs, 8'd0);
    check_order(1);
    finish_test("normal high-capacity card", err0);
  endtask

  task automatic block_read();
    int err0;
    err0 = errors;
    set_card(r1_idle, 8'hAA, 1'b1, 4'd0, 1'b0);
    apply_reset();
    wait_end();
    cmp_bit("init_done", init_done, 1'b1);
    check_block();
    finish_test("block read", err0);
  endtask

  task automatic cmd0_never_idle();
    int err0;
    err0 = errors;
    set_card(8'h00, 8'hAA, 1'b1, 4'd0, 1'b0);
    apply_reset();
    wait_end();
    cmp_bit("init_error", init_error, 1'b1);
    cmp_bit("init_done", init_done, 1'b0);
    cmp_r1("CMD0 frames", n_cmd0, 8'd10);
    finish_test("CMD0 never idle", err0);
  endtask

  task automatic acmd41_busy_polls();
    int err0;
    err0 = errors;
    // standard capacity card, three busy polls
    set_card(r1_idle, 8'hAA, 1'b0, 4'd3, 1'b0);
    apply_reset();
    wait_end();
    cmp_bit("init_done", init_done, 1'b1);
    cmp_bit("card_hc", card_hc, 1'b0);
    cmp_r1("CMD55 frames", n_cmd55, 8'd4);
    cmp_r1("crc7 mismatches", crc_errs, 8'd0);
    check_order(3);
    check_block();
    finish_test("ACMD41 busy three times", err0);
  endtask

  task automatic bad_cmd8_then_mute();
    int err0;
    err0 = errors;
    set_card(r1_idle, 8'h55, 1'b1, 4'd0, 1'b0);
    apply_reset();
    wait_end();
    cmp_bit("init_error on bad pattern", init_error, 1'b1);
    cmp_bit("init_done on bad pattern", init_done, 1'b0);
    cmp_r1("CMD8 frames", n_cmd8, 8'd1);
    // card that never answers
    set_card(r1_idle, 8'hAA, 1'b1, 4'd0, 1'b1);
    apply_reset();
    wait_end();
    cmp_bit("init_error on mute card", init_error, 1'b1);
    cmp_bit("init_done on mute card", init_done, 1'b0);
    cmp_r1("CMD0 frames on mute card", n_cmd0, 8'd10);
    finish_test("bad CMD8 pattern and mute card", err0);
  endtask

  initial begin
    rst_req = 1'b0;
    cmd0_r1 = r1_idle;
    cmd8_pattern = 8'hAA;
    ocr_hc = 1'b1;
    busy_polls = 4'd0;
    mute = 1'b0;
    normal_hc_card();
    block_read();
    cmd0_never_idle();
    acmd41_busy_polls();
    bad_cmd8_then_mute();
    $display("tests run %0d, failed %0d, errors %0d", n_tests, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- flist.f
src/sd_pkg.sv
src/sd_if.sv
src/sd_clk_gen.sv
src/sd_cmd_tx.sv
src/sd_resp_rx.sv
src/sd_init_seq.sv
src/sd_spi_init.sv
dv/tb_clk_gen.sv
dv/sd_card_model.sv
dv/tb_sd_spi_init.sv
